/* verilog.f */
+incdir+.
rvCtrlPkg.sv
instrDecode.sv
execSequencer.sv
retireUnit.sv
rvController.sv
rvController_checker.sv
rvController_tb.sv

/* rvController_tb.sv */
// Self-checking rvController testbench, runs an instruction table against register and ALU models
`timescale 1ns/1ns
`default_nettype none

`include "rvCtrl_macros.svh"

module rvControllerTb;

    typedef struct packed {
        logic [`XLEN-1:0]       word;
        logic [`XLEN-1:0]       pc;
        logic [`XLEN-1:0]       rs1Val;    // Also the expected operand A
        logic [`XLEN-1:0]       rs2Val;
        rvCtrlPkg::aluOpT       op;        // First ALU pass
        logic [`XLEN-1:0]       opB;
        logic                   writeEn;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`XLEN-1:0]       value;
        logic [`XLEN-1:0]       nextPc;
        logic                   usesAlu;   // Low for unsupported opcodes
        logic                   taken;
    } vectorT;

    localparam logic [`XLEN-1:0] pcBase = 32'h0000_0100;

    logic              clk = 1'b0;
    logic              reset;
    logic              instrValid;
    logic              instrReady;
    logic [`XLEN-1:0]  instrWord;
    logic [`XLEN-1:0]  instrPc;
    logic              regReqValid;
    logic              regReqReady = 1'b0;
    rvCtrlPkg::regReqT regReq;
    logic              regDataValid = 1'b0;
    logic [`XLEN-1:0]  rs1Data = '0;
    logic [`XLEN-1:0]  rs2Data = '0;
    logic              aluReqValid;
    logic              aluReqReady = 1'b0;
    rvCtrlPkg::aluReqT aluReq;
    logic              aluRespValid = 1'b0;
    logic [`XLEN-1:0]  aluResult = '0;
    logic              retireValid;
    logic              retireReady = 1'b0;
    rvCtrlPkg::retireT retire;

    vectorT            vectors [32];
    rvCtrlPkg::aluReqT expAlu [$];   // Every ALU pass in program order
    int                nVec = 0;
    int                expRegs = 0;
    int                regPtr = 0;
    int                regCount = 0;
    int                aluIdx = 0;
    int                retIdx = 0;
    int                regWait = 0;
    int                aluWait = 0;
    logic              regBusy = 1'b0;
    logic              aluBusy = 1'b0;
    logic [`XLEN-1:0]  aluHold = '0;
    logic [15:0]       lfsr = 16'd42883;
    int                mismatches = 0;
    int                otherErrors = 0;

    rvController DUT (.*);

    always #5 clk = ~clk;

    // x^16 + x^14 + x^13 + x^11, one step per bit
    function automatic logic [1:0] lfsrTwoBits();
        logic [1:0] bits;
        logic       fb;
        bits = '0;
        repeat (2)
        begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            bits = {bits[0], fb};
        end
        return bits;
    endfunction

    // External ALU behavior
    function automatic logic [`XLEN-1:0] aluModel(input rvCtrlPkg::aluReqT req);
        logic [`XLEN-1:0] a;
        logic [`XLEN-1:0] b;
        a = req.operandA;
        b = req.operandB;
        case (req.aluOp)
            rvCtrlPkg::aluAdd:  return a + b;
            rvCtrlPkg::aluSub:  return a - b;
            rvCtrlPkg::aluMul:  return a * b;
            rvCtrlPkg::aluSll:  return a << b[4:0];
            rvCtrlPkg::aluSrl:  return a >> b[4:0];
            rvCtrlPkg::aluSra:  return $signed(a) >>> b[4:0];
            rvCtrlPkg::aluSlt:  return {31'b0, $signed(a) < $signed(b)};
            rvCtrlPkg::aluSltu: return {31'b0, a < b};
            rvCtrlPkg::aluXor:  return a ^ b;
            rvCtrlPkg::aluOr:   return a | b;
            rvCtrlPkg::aluAnd:  return a & b;
            rvCtrlPkg::aluEq:   return {31'b0, a == b};
            default:            return '0;
        endcase
    endfunction

    task automatic compare(input logic [`XLEN-1:0] got, input logic [`XLEN-1:0] exp,
                           input string what);
        if (got !== exp)
        begin
            mismatches++;
            $display("Mismatch at %0t ns: %s got %h, expected %h", $time, what, got, exp);
        end
    endtask

    // R-type, always rs1 = x1 and rs2 = x2
    task automatic regVector(input logic [6:0] f7, input logic [2:0] f3, input logic [4:0] rd,
                             input logic [`XLEN-1:0] a, input logic [`XLEN-1:0] b,
                             input rvCtrlPkg::aluOpT op, input logic [`XLEN-1:0] value);
        logic [`XLEN-1:0] pc;
        pc = pcBase + `PC_STEP * nVec;
        vectors[nVec] = '{word: {f7, 5'd2, 5'd1, f3, rd, 7'b0110011}, pc: pc, rs1Val: a,
                          rs2Val: b, op: op, opB: b, writeEn: rd != 0, rd: rd, value: value,
                          nextPc: pc + `PC_STEP, usesAlu: 1'b1, taken: 1'b0};
        nVec++;
    endtask

    // I-type, opB is the operand the ALU should see
    task automatic immVector(input logic [2:0] f3, input logic [11:0] imm, input logic [4:0] rd,
                             input logic [`XLEN-1:0] a, input rvCtrlPkg::aluOpT op,
                             input logic [`XLEN-1:0] opB, input logic [`XLEN-1:0] value);
        logic [`XLEN-1:0] pc;
        pc = pcBase + `PC_STEP * nVec;
        vectors[nVec] = '{word: {imm, 5'd1, f3, rd, 7'b0010011}, pc: pc, rs1Val: a, rs2Val: '0,
                          op: op, opB: opB, writeEn: rd != 0, rd: rd, value: value,
                          nextPc: pc + `PC_STEP, usesAlu: 1'b1, taken: 1'b0};
        nVec++;
    endtask

    // BEQ when f3 is 000, BNE when 001, off is the 13-bit byte offset
    task automatic branchVector(input logic [2:0] f3, input logic [12:0] off,
                                input logic [`XLEN-1:0] a, input logic [`XLEN-1:0] b);
        logic [`XLEN-1:0] pc;
        logic [`XLEN-1:0] target;
        logic [`XLEN-1:0] word;
        logic             taken;
        pc     = pcBase + `PC_STEP * nVec;
        target = pc + {{19{off[12]}}, off};
        word   = {off[12], off[10:5], 5'd2, 5'd1, f3, off[4:1], off[11], 7'b1100011};
        taken  = f3[0] ? (a != b) : (a == b);
        vectors[nVec] = '{word: word, pc: pc, rs1Val: a, rs2Val: b, op: rvCtrlPkg::aluEq,
                          opB: b, writeEn: 1'b0, rd: word[11:7],
                          value: taken ? target : {31'b0, a == b},
                          nextPc: taken ? target : pc + `PC_STEP, usesAlu: 1'b1, taken: taken};
        nVec++;
    endtask

    task automatic illegalVector(input logic [`XLEN-1:0] word);
        logic [`XLEN-1:0] pc;
        pc = pcBase + `PC_STEP * nVec;
        vectors[nVec] = '{word: word, pc: pc, rs1Val: '0, rs2Val: '0, op: rvCtrlPkg::aluAdd,
                          opB: '0, writeEn: 1'b0, rd: word[11:7], value: '0,
                          nextPc: pc + `PC_STEP, usesAlu: 1'b0, taken: 1'b0};
        nVec++;
    endtask

    task automatic buildVectors();
        regVector(7'b0000000, 3'b000, 5'd3, 32'd7, 32'd5, rvCtrlPkg::aluAdd, 32'd12);
        regVector(7'b0100000, 3'b000, 5'd4, 32'd7, 32'd5, rvCtrlPkg::aluSub, 32'd2);
        regVector(7'b0000001, 3'b000, 5'd5, 32'd6, 32'd7, rvCtrlPkg::aluMul, 32'd42);
        regVector(7'b0000000, 3'b001, 5'd6, 32'd3, 32'd4, rvCtrlPkg::aluSll, 32'd48);
        regVector(7'b0000000, 3'b010, 5'd7, 32'hFFFFFFFE, 32'd1, rvCtrlPkg::aluSlt, 32'd1);
        regVector(7'b0000000, 3'b011, 5'd8, 32'hFFFFFFFE, 32'd1, rvCtrlPkg::aluSltu, 32'd0);
        regVector(7'b0000000, 3'b100, 5'd9, 32'h0000F0F0, 32'h0FF0, rvCtrlPkg::aluXor, 32'hFF00);
        regVector(7'b0000000, 3'b101, 5'd10, 32'h80000000, 32'd4, rvCtrlPkg::aluSrl, 32'h08000000);
        regVector(7'b0100000, 3'b101, 5'd11, 32'h80000000, 32'd4, rvCtrlPkg::aluSra, 32'hF8000000);
        regVector(7'b0000000, 3'b110, 5'd12, 32'h0000F000, 32'h000F, rvCtrlPkg::aluOr, 32'hF00F);
        regVector(7'b0000000, 3'b111, 5'd13, 32'h0000FF00, 32'h0FF0, rvCtrlPkg::aluAnd, 32'h0F00);
        regVector(7'b0000000, 3'b000, 5'd0, 32'd7, 32'd5, rvCtrlPkg::aluAdd, 32'd12);   // x0
        immVector(3'b000, 12'hFFD, 5'd14, 32'd10, rvCtrlPkg::aluAdd, 32'hFFFFFFFD, 32'd7);
        immVector(3'b001, 12'h005, 5'd15, 32'd1, rvCtrlPkg::aluSll, 32'd5, 32'd32);
        immVector(3'b010, 12'hFFF, 5'd16, 32'hFFFFFFFE, rvCtrlPkg::aluSlt, 32'hFFFFFFFF, 32'd1);
        immVector(3'b011, 12'h800, 5'd17, 32'd5, rvCtrlPkg::aluSltu, 32'hFFFFF800, 32'd1);
        immVector(3'b100, 12'h0FF, 5'd18, 32'h000000F0, rvCtrlPkg::aluXor, 32'h0FF, 32'h00F);
        immVector(3'b101, 12'h008, 5'd19, 32'h80000000, rvCtrlPkg::aluSrl, 32'd8, 32'h00800000);
        immVector(3'b101, 12'h408, 5'd20, 32'h80000000, rvCtrlPkg::aluSra, 32'd8, 32'hFF800000);
        immVector(3'b110, 12'h700, 5'd21, 32'h0000000F, rvCtrlPkg::aluOr, 32'h700, 32'h70F);
        immVector(3'b111, 12'hF0F, 5'd22, 32'h00001234, rvCtrlPkg::aluAnd, 32'hFFFFFF0F, 32'h1204);
        branchVector(3'b000, 13'd16, 32'd9, 32'd9);     // BEQ taken
        branchVector(3'b000, 13'd16, 32'd9, 32'd8);     // BEQ not taken
        branchVector(3'b001, 13'h1FF8, 32'd1, 32'd2);   // BNE taken, backward
        branchVector(3'b001, 13'd32, 32'd3, 32'd3);     // BNE not taken
        illegalVector(32'h123450B7);                    // LUI x1
        // Compare pass, then pc + offset when taken
        for (int i = 0; i < nVec; i++)
        begin
            if (vectors[i].usesAlu)
            begin
                expRegs++;
                expAlu.push_back('{aluOp: vectors[i].op, operandA: vectors[i].rs1Val,
                                   operandB: vectors[i].opB});
                if (vectors[i].taken)
                    expAlu.push_back('{aluOp: rvCtrlPkg::aluAdd, operandA: vectors[i].pc,
                                       operandB: vectors[i].nextPc - vectors[i].pc});
            end
        end
    endtask

    task automatic report();
        int assertFails;
        assertFails = DUT.handshakeCheck.failCount;
        $display("Errors: %0d mismatches, %0d other failures, %0d assertion failures",
                 mismatches, otherErrors, assertFails);
        if (mismatches == 0 && otherErrors == 0 && assertFails == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    endtask

    // Register file, ALU and retire consumer models, all stepped on the falling edge
    always @(negedge clk)
    begin : responders
        vectorT v;
        regDataValid = 1'b0;
        if (regBusy)
        begin
            if (regWait == 0)
            begin
                regDataValid = 1'b1;
                rs1Data      = vectors[regPtr].rs1Val;
                rs2Data      = vectors[regPtr].rs2Val;
                regBusy      = 1'b0;
                regPtr++;
            end
            else
                regWait--;
        end
        regReqReady = lfsrTwoBits() != 2'b00;
        if (regReqValid && regReqReady)   // Transfers at the next rising edge
        begin
            while (regPtr < nVec && !vectors[regPtr].usesAlu)
                regPtr++;   // No register read for unsupported opcodes
            if (regPtr >= nVec)
            begin
                otherErrors++;
                $display("Register request at %0t ns with no instruction left to serve", $time);
            end
            else
            begin
                compare(regReq.rs1, vectors[regPtr].word[19:15],
                        $sformatf("instr %0d regReq rs1", regPtr));
                compare(regReq.usesRs2, vectors[regPtr].word[6:0] != 7'b0010011,
                        $sformatf("instr %0d regReq usesRs2", regPtr));
                if (vectors[regPtr].word[6:0] != 7'b0010011)   // rs2 only read when used
                    compare(regReq.rs2, vectors[regPtr].word[24:20],
                            $sformatf("instr %0d regReq rs2", regPtr));
                regCount++;
                regBusy = 1'b1;
                regWait = lfsrTwoBits();
            end
        end

        aluRespValid = 1'b0;
        if (aluBusy)
        begin
            if (aluWait == 0)
            begin
                aluRespValid = 1'b1;
                aluResult    = aluHold;
                aluBusy      = 1'b0;
            end
            else
                aluWait--;
        end
        aluReqReady = lfsrTwoBits() != 2'b00;
        if (aluReqValid && aluReqReady)
        begin
            if (aluIdx >= expAlu.size())
            begin
                otherErrors++;
                $display("ALU request at %0t ns beyond the expected sequence", $time);
            end
            else
            begin
                compare(aluReq.aluOp, expAlu[aluIdx].aluOp, $sformatf("ALU pass %0d op", aluIdx));
                compare(aluReq.operandA, expAlu[aluIdx].operandA,
                        $sformatf("ALU pass %0d operandA", aluIdx));
                compare(aluReq.operandB, expAlu[aluIdx].operandB,
                        $sformatf("ALU pass %0d operandB", aluIdx));
            end
            aluIdx++;
            aluHold = aluModel(aluReq);   // Answer anyway so the DUT keeps moving
            aluBusy = 1'b1;
            aluWait = lfsrTwoBits();
        end

        retireReady = lfsrTwoBits() != 2'b00;
        if (retireValid && retireReady)
        begin
            if (retIdx >= nVec)
            begin
                otherErrors++;
                $display("Extra retire at %0t ns after all instructions retired", $time);
            end
            else
            begin
                v = vectors[retIdx];
                compare(retire.writeEn, v.writeEn, $sformatf("instr %0d writeEn", retIdx));
                compare(retire.rd, v.rd, $sformatf("instr %0d rd", retIdx));
                compare(retire.value, v.value, $sformatf("instr %0d value", retIdx));
                compare(retire.nextPc, v.nextPc, $sformatf("instr %0d nextPc", retIdx));
            end
            retIdx++;
        end
    end

    initial
    begin
        int   waitCycles;
        logic stuck;
        reset      = 1'b1;
        instrValid = 1'b0;
        instrWord  = '0;
        instrPc    = '0;
        stuck      = 1'b0;
        buildVectors();
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        for (int i = 0; i < nVec && !stuck; i++)
        begin
            instrValid = 1'b1;
            instrWord  = vectors[i].word;
            instrPc    = vectors[i].pc;
            waitCycles = 0;
            while (!instrReady && waitCycles < 200)
            begin
                @(negedge clk);
                waitCycles++;
            end
            if (!instrReady)
            begin
                otherErrors++;
                $display("Timeout: instruction %0d was never accepted", i);
                stuck = 1'b1;
            end
            else
                @(negedge clk);   // Accepted on the rising edge in between
        end
        instrValid = 1'b0;

        if (!stuck)
        begin
            waitCycles = 0;
            while (retIdx < nVec && waitCycles < 2000)
            begin
                @(posedge clk);
                waitCycles++;
            end
            if (retIdx < nVec)
            begin
                otherErrors++;
                $display("Timeout: only %0d of %0d instructions retired", retIdx, nVec);
            end
            repeat (8) @(posedge clk);   // Room for any stray transfer
            if (aluIdx != expAlu.size() || regCount != expRegs)
            begin
                otherErrors++;
                $display("Saw %0d ALU and %0d register requests, expected %0d and %0d",
                         aluIdx, regCount, expAlu.size(), expRegs);
            end
        end
        report();
    end

endmodule

`default_nettype wire

/* rvController_checker.sv */
// Handshake and reset assertions for rvController, attached to every DUT instance through bind
`timescale 1ns/1ns
`default_nettype none

module rvControllerChecker (
    input logic              clk,
    input logic              reset,
    input logic              instrReady,
    input logic              regReqValid,
    input logic              regReqReady,
    input rvCtrlPkg::regReqT regReq,
    input logic              aluReqValid,
    input logic              aluReqReady,
    input rvCtrlPkg::aluReqT aluReq,
    input logic              retireValid,
    input logic              retireReady,
    input rvCtrlPkg::retireT retire
);

    int failCount = 0;   // Read by the testbench summary

    // Stalled request keeps valid and payload
    assert property (@(posedge clk) disable iff (reset)
                     regReqValid && !regReqReady |=> regReqValid && $stable(regReq))
    else
    begin
        failCount++;
        $error("regReq dropped or changed while stalled");
    end

    assert property (@(posedge clk) disable iff (reset)
                     aluReqValid && !aluReqReady |=> aluReqValid && $stable(aluReq))
    else
    begin
        failCount++;
        $error("aluReq dropped or changed while stalled");
    end

    assert property (@(posedge clk) disable iff (reset)
                     retireValid && !retireReady |=> retireValid && $stable(retire))
    else
    begin
        failCount++;
        $error("retire record dropped or changed while stalled");
    end

    // Idle handshake state while reset holds
    assert property (@(posedge clk)
                     reset |-> instrReady && !regReqValid && !aluReqValid && !retireValid)
    else
    begin
        failCount++;
        $error("handshake outputs not in reset state");
    end

endmodule

bind rvController rvControllerChecker handshakeCheck (
    .clk(clk), .reset(reset), .instrReady(instrReady),
    .regReqValid(regReqValid), .regReqReady(regReqReady), .regReq(regReq),
    .aluReqValid(aluReqValid), .aluReqReady(aluReqReady), .aluReq(aluReq),
    .retireValid(retireValid), .retireReady(retireReady), .retire(retire)
);

`default_nettype wire

/* rvController.sv */
// Controller top, connects decode, execute and retire stages to the external register file and ALU
`timescale 1ns/1ns
`default_nettype none

`include "rvCtrl_macros.svh"

module rvController (
    input  logic              clk,
    input  logic              reset,
    input  logic              instrValid,
    output logic              instrReady,
    input  logic [`XLEN-1:0]  instrWord,
    input  logic [`XLEN-1:0]  instrPc,
    output logic              regReqValid,
    input  logic              regReqReady,
    output rvCtrlPkg::regReqT regReq,
    input  logic              regDataValid,
    input  logic [`XLEN-1:0]  rs1Data,
    input  logic [`XLEN-1:0]  rs2Data,
    output logic              aluReqValid,
    input  logic              aluReqReady,
    output rvCtrlPkg::aluReqT aluReq,
    input  logic              aluRespValid,
    input  logic [`XLEN-1:0]  aluResult,
    output logic              retireValid,
    input  logic              retireReady,
    output rvCtrlPkg::retireT retire
);

    logic               decValid;   // Decode to execute
    logic               decReady;
    rvCtrlPkg::decodedT dec;
    logic               resValid;   // Execute to retire
    logic               resReady;
    rvCtrlPkg::resultT  res;

    instrDecode decodeStage (
        .clk(clk), .reset(reset),
        .instrValid(instrValid), .instrWord(instrWord), .instrPc(instrPc),
        .decReady(decReady), .instrReady(instrReady), .decValid(decValid), .dec(dec)
    );

    execSequencer seqStage (
        .clk(clk), .reset(reset), .decValid(decValid), .dec(dec),
        .regReqReady(regReqReady), .regDataValid(regDataValid),
        .rs1Data(rs1Data), .rs2Data(rs2Data),
        .aluReqReady(aluReqReady), .aluRespValid(aluRespValid), .aluResult(aluResult),
        .resReady(resReady), .decReady(decReady),
        .regReqValid(regReqValid), .regReq(regReq),
        .aluReqValid(aluReqValid), .aluReq(aluReq),
        .resValid(resValid), .res(res)
    );

    retireUnit retireStage (
        .clk(clk), .reset(reset), .resValid(resValid), .res(res),
        .retireReady(retireReady), .resReady(resReady),
        .retireValid(retireValid), .retire(retire)
    );

endmodule

`default_nettype wire

/* retireUnit.sv */
// Retire slot, forms writeback and next PC and holds them until the consumer takes them
`timescale 1ns/1ns
`default_nettype none

`include "rvCtrl_macros.svh"

module retireUnit (
    input  logic              clk,
    input  logic              reset,
    input  logic              resValid,
    input  rvCtrlPkg::resultT res,
    input  logic              retireReady,
    output logic              resReady,
    output logic              retireValid,
    output rvCtrlPkg::retireT retire
);

    logic slotFull;
    logic takeRes;

    assign takeRes     = resValid && resReady;
    assign resReady    = !slotFull || retireReady;   // Room now or after this edge
    assign retireValid = slotFull;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            slotFull <= 1'b0;
        else if (takeRes)
            slotFull <= 1'b1;
        else if (retireReady)
            slotFull <= 1'b0;
    end

    always_ff @(posedge clk)
    begin
        if (takeRes)
        begin
            retire.writeEn <= res.writeEn && (res.rd != '0);   // x0 writes dropped
            retire.rd      <= res.rd;
            retire.value   <= res.value;
            // Sequential flow unless a branch was taken
            retire.nextPc  <= res.taken ? res.value : res.pc + `XLEN'(`PC_STEP);
        end
    end

endmodule

`default_nettype wire

/* execSequencer.sv */
// Execute FSM, fetches operands, drives the external ALU and resolves branches for one instruction
`timescale 1ns/1ns
`default_nettype none

`include "rvCtrl_macros.svh"

module execSequencer (
    input  logic               clk,
    input  logic               reset,
    input  logic               decValid,
    input  rvCtrlPkg::decodedT dec,
    input  logic               regReqReady,
    input  logic               regDataValid,
    input  logic [`XLEN-1:0]   rs1Data,
    input  logic [`XLEN-1:0]   rs2Data,
    input  logic               aluReqReady,
    input  logic               aluRespValid,
    input  logic [`XLEN-1:0]   aluResult,
    input  logic               resReady,
    output logic               decReady,
    output logic               regReqValid,
    output rvCtrlPkg::regReqT  regReq,
    output logic               aluReqValid,
    output rvCtrlPkg::aluReqT  aluReq,
    output logic               resValid,
    output rvCtrlPkg::resultT  res
);

    rvCtrlPkg::seqStateT state;
    rvCtrlPkg::decodedT  cur;          // Instruction in execution
    logic                isBranch;
    logic                branchTaken;

    assign isBranch = (cur.opcode == rvCtrlPkg::opBranch);

    // Eq pass returns 1 on equal
    assign branchTaken = (cur.branchCond == rvCtrlPkg::brEq) ? (aluResult != '0)
                                                             : (aluResult == '0);

    assign decReady    = (state == rvCtrlPkg::sIdle);
    assign regReqValid = (state == rvCtrlPkg::sRegReq);
    assign aluReqValid = (state == rvCtrlPkg::sAluReq) || (state == rvCtrlPkg::sTgtReq);
    assign resValid    = (state == rvCtrlPkg::sResult);

    assign regReq = '{rs1: cur.rs1, rs2: cur.rs2, usesRs2: cur.usesRs2};

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            state <= rvCtrlPkg::sIdle;
        else
        begin
            case (state)
                rvCtrlPkg::sIdle:
                begin
                    if (decValid)   // Unsupported opcodes go straight to result
                        state <= (dec.opcode == rvCtrlPkg::opIllegal) ? rvCtrlPkg::sResult
                                                                       : rvCtrlPkg::sRegReq;
                end
                rvCtrlPkg::sRegReq:  if (regReqReady) state <= rvCtrlPkg::sRegWait;
                rvCtrlPkg::sRegWait: if (regDataValid) state <= rvCtrlPkg::sAluReq;
                rvCtrlPkg::sAluReq:  if (aluReqReady) state <= rvCtrlPkg::sAluWait;
                rvCtrlPkg::sAluWait:
                begin
                    if (aluRespValid)
                        state <= (isBranch && branchTaken) ? rvCtrlPkg::sTgtReq
                                                           : rvCtrlPkg::sResult;
                end
                rvCtrlPkg::sTgtReq:  if (aluReqReady) state <= rvCtrlPkg::sTgtWait;
                rvCtrlPkg::sTgtWait: if (aluRespValid) state <= rvCtrlPkg::sResult;
                rvCtrlPkg::sResult:  if (resReady) state <= rvCtrlPkg::sIdle;
                default:             state <= rvCtrlPkg::sIdle;
            endcase
        end
    end

    // Payload registers, only loaded on the step that owns them
    always_ff @(posedge clk)
    begin
        case (state)
            rvCtrlPkg::sIdle:
            begin
                if (decValid)
                begin
                    cur <= dec;
                    res <= '{writeEn: 1'b0, rd: dec.rd, value: '0, pc: dec.pc, taken: 1'b0};
                end
            end
            rvCtrlPkg::sRegWait:
            begin
                if (regDataValid)   // Immediate replaces rs2 for opImm
                    aluReq <= '{aluOp: cur.aluOp, operandA: rs1Data,
                                operandB: (cur.opcode == rvCtrlPkg::opImm) ? cur.imm : rs2Data};
            end
            rvCtrlPkg::sAluWait:
            begin
                if (aluRespValid)
                begin
                    res.value   <= aluResult;
                    res.writeEn <= !isBranch;
                    if (isBranch && branchTaken)   // Second pass, pc + offset
                        aluReq <= '{aluOp: rvCtrlPkg::aluAdd, operandA: cur.pc, operandB: cur.imm};
                end
            end
            rvCtrlPkg::sTgtWait:
            begin
                if (aluRespValid)
                begin
                    res.value <= aluResult;   // Branch target
                    res.taken <= 1'b1;
                end
            end
            default:
            begin
            end
        endcase
    end

endmodule

`default_nettype wire

/* instrDecode.sv */
// One-entry decode slot, takes an instruction word and PC and hands a decoded record to execute
`timescale 1ns/1ns
`default_nettype none

`include "rvCtrl_macros.svh"

module instrDecode (
    input  logic                clk,
    input  logic                reset,
    input  logic                instrValid,
    input  logic [`XLEN-1:0]    instrWord,
    input  logic [`XLEN-1:0]    instrPc,
    input  logic                decReady,
    output logic                instrReady,
    output logic                decValid,
    output rvCtrlPkg::decodedT  dec
);

    logic                 slotFull;
    rvCtrlPkg::decodedT   decNext;
    logic [`OPCODE_W-1:0] opField;
    logic [2:0]           funct3;
    logic [6:0]           funct7;   // imm[11:5] for I-type shifts

    // Shared by R-type and I-type, sub and mul only exist for registers
    function automatic rvCtrlPkg::aluOpT aluOpFor(input logic [2:0] f3, input logic [6:0] f7,
                                                  input logic isReg);
        rvCtrlPkg::aluOpT op;
        case (f3)
            3'b000:
            begin
                if (isReg && f7 == 7'b0100000)
                    op = rvCtrlPkg::aluSub;
                else if (isReg && f7 == 7'b0000001)
                    op = rvCtrlPkg::aluMul;
                else
                    op = rvCtrlPkg::aluAdd;
            end
            3'b001:  op = rvCtrlPkg::aluSll;
            3'b010:  op = rvCtrlPkg::aluSlt;
            3'b011:  op = rvCtrlPkg::aluSltu;
            3'b100:  op = rvCtrlPkg::aluXor;
            3'b101:  op = f7[5] ? rvCtrlPkg::aluSra : rvCtrlPkg::aluSrl;   // Arithmetic bit
            3'b110:  op = rvCtrlPkg::aluOr;
            default: op = rvCtrlPkg::aluAnd;
        endcase
        return op;
    endfunction

    assign opField = instrWord[`OPCODE_W-1:0];
    assign funct3  = instrWord[14:12];
    assign funct7  = instrWord[31:25];

    assign instrReady = !slotFull || decReady;   // Empty, or draining this cycle
    assign decValid   = slotFull;

    always_comb
    begin
        decNext            = '0;
        decNext.rs1        = instrWord[19:15];
        decNext.rs2        = instrWord[24:20];
        decNext.rd         = instrWord[11:7];
        decNext.pc         = instrPc;
        decNext.branchCond = funct3[0] ? rvCtrlPkg::brNe : rvCtrlPkg::brEq;
        decNext.imm        = {{(`XLEN-`IMM_W){instrWord[31]}}, instrWord[31:20]};
        case (opField)
            rvCtrlPkg::opImm:
            begin
                decNext.opcode = rvCtrlPkg::opImm;
                decNext.aluOp  = aluOpFor(funct3, funct7, 1'b0);
                if (funct3 == 3'b001 || funct3 == 3'b101)
                    decNext.imm = `XLEN'(instrWord[24:20]);   // shamt
            end
            rvCtrlPkg::opReg:
            begin
                decNext.opcode  = rvCtrlPkg::opReg;
                decNext.aluOp   = aluOpFor(funct3, funct7, 1'b1);
                decNext.usesRs2 = 1'b1;
            end
            rvCtrlPkg::opBranch:
            begin
                decNext.opcode  = rvCtrlPkg::opBranch;
                decNext.aluOp   = rvCtrlPkg::aluEq;   // First pass compares
                decNext.usesRs2 = 1'b1;
                // B-type offset imm[12:1], bit 0 always zero
                decNext.imm     = {{(`XLEN-`IMM_W-1){instrWord[31]}}, instrWord[31], instrWord[7],
                                   instrWord[30:25], instrWord[11:8], 1'b0};
            end
            default:
            begin
                decNext.opcode = rvCtrlPkg::opIllegal;   // Retires as no-op
                decNext.aluOp  = rvCtrlPkg::aluAdd;
            end
        endcase
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            slotFull <= 1'b0;
        else if (instrValid && instrReady)
            slotFull <= 1'b1;
        else if (decReady)
            slotFull <= 1'b0;
    end

    always_ff @(posedge clk)
    begin
        if (instrValid && instrReady)
            dec <= decNext;
    end

endmodule

`default_nettype wire

/* rvCtrlPkg.sv */
// Types shared by the controller stages, referenced by scoped name from each module
`default_nettype none

`include "rvCtrl_macros.svh"

package rvCtrlPkg;

    // Values match the RISC-V major opcodes so decode can compare directly
    typedef enum logic [`OPCODE_W-1:0] {
        opImm     = 7'b0010011,
        opReg     = 7'b0110011,
        opBranch  = 7'b1100011,
        opIllegal = 7'b1111111   // Anything not listed above
    } opcodeT;

    // External ALU function select
    typedef enum logic [4:0] {
        aluAdd  = 5'b00000,
        aluSub  = 5'b00001,
        aluMul  = 5'b00010,
        aluSll  = 5'b00100,
        aluSrl  = 5'b00101,
        aluEq   = 5'b00110,  // 1 when operands equal
        aluAnd  = 5'b01000,
        aluOr   = 5'b01001,
        aluXor  = 5'b01010,
        aluSltu = 5'b01101,
        aluSlt  = 5'b01110,
        aluSra  = 5'b01111
    } aluOpT;

    typedef enum logic {brEq = 1'b0, brNe = 1'b1} branchCondT;   // funct3[0]

    typedef struct packed {
        opcodeT                 opcode;
        aluOpT                  aluOp;
        branchCondT             branchCond;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`XLEN-1:0]       imm;       // Sign-extended, shamt or branch offset
        logic                   usesRs2;
        logic [`XLEN-1:0]       pc;
    } decodedT;

    typedef struct packed {
        logic [`REG_ADDR_W-1:0] rs1;
        logic [`REG_ADDR_W-1:0] rs2;
        logic                   usesRs2;   // Low means rs2Data is don't-care
    } regReqT;

    typedef struct packed {
        aluOpT            aluOp;
        logic [`XLEN-1:0] operandA;
        logic [`XLEN-1:0] operandB;
    } aluReqT;

    // Execute to retire, nextPc still to be formed
    typedef struct packed {
        logic                   writeEn;   // ALU op, before x0 masking
        logic [`REG_ADDR_W-1:0] rd;
        logic [`XLEN-1:0]       value;     // ALU result, or target when taken
        logic [`XLEN-1:0]       pc;
        logic                   taken;
    } resultT;

    typedef struct packed {
        logic                   writeEn;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`XLEN-1:0]       value;
        logic [`XLEN-1:0]       nextPc;
    } retireT;

    typedef enum logic [2:0] {
        sIdle, sRegReq, sRegWait, sAluReq, sAluWait, sTgtReq, sTgtWait, sResult
    } seqStateT;

endpackage

`default_nettype wire

/* rvCtrl_macros.svh */
// Width and step constants shared by the controller package and RTL, include once per file
`ifndef RV_CTRL_MACROS_SVH
`define RV_CTRL_MACROS_SVH

// Data path and program counter width
`define XLEN 32

// Register file addressing, x0..x31
`define REG_ADDR_W 5

// Major opcode field, instrWord[6:0]
`define OPCODE_W 7

// I-type and B-type short immediate
`define IMM_W 12

// Byte-addressed PC, one word per instruction
`define PC_STEP 4

`endif
